// File: compile.f
hw/fhe_buf_pkg.sv
hw/buf_xbar_if.sv
hw/cmd_decoder.sv
hw/buffer_interconnect.sv
hw/buffer_slot_bank.sv
hw/lane_alu.sv
hw/result_port.sv
hw/fhe_buffer_top.sv
verification/tb_fhe_buffer.sv

// File: hw/buf_xbar_if.sv
`timescale 1ns/1ns
`default_nettype none

interface buf_xbar_if;

    // lane side requests, driven by the decoder
    fhe_buf_pkg::slot_req_t [fhe_buf_pkg::NUM_LANES-1:0] lane_req;

    // per slot, which lane request reaches that slot
    logic [fhe_buf_pkg::NUM_SLOTS-1:0][fhe_buf_pkg::LANE_SEL_W-1:0] slot_select;
    // per lane, which slot read data reaches that lane
    logic [fhe_buf_pkg::NUM_LANES-1:0][fhe_buf_pkg::SLOT_SEL_W-1:0] lane_select;

    // routed requests into the ram bank and its read data
    fhe_buf_pkg::slot_req_t [fhe_buf_pkg::NUM_SLOTS-1:0] slot_req;
    logic [fhe_buf_pkg::NUM_SLOTS-1:0][fhe_buf_pkg::WORD_W-1:0] slot_rdata;

    modport ctrl (
        output lane_req,
        output slot_select,
        output lane_select
    );

    modport xbar (
        input  lane_req,
        input  slot_select,
        input  lane_select,
        output slot_req,
        input  slot_rdata
    );

    modport bank (
        input  slot_req,
        output slot_rdata
    );

endinterface

`default_nettype wire

// File: hw/buffer_interconnect.sv
`timescale 1ns/1ns
`default_nettype none

module buffer_interconnect (
    input  wire logic clk,
    input  wire logic rst,
    buf_xbar_if.xbar  xb,
    output logic [fhe_buf_pkg::NUM_LANES-1:0][fhe_buf_pkg::WORD_W-1:0] lane_data
);

    // lane selects delayed to line up with ram read data
    logic [fhe_buf_pkg::NUM_LANES-1:0][fhe_buf_pkg::SLOT_SEL_W-1:0] lane_sel_d1;
    logic [fhe_buf_pkg::NUM_LANES-1:0][fhe_buf_pkg::SLOT_SEL_W-1:0] lane_sel_d2;

    // one registered lane to slot mux per slot
    always_ff @(posedge clk) begin
        for (int s = 0; s < fhe_buf_pkg::NUM_SLOTS; s++) begin
            xb.slot_req[s] <= xb.lane_req[xb.slot_select[s]];
        end
        // reset clears only the write enables
        if (rst) begin
            for (int s = 0; s < fhe_buf_pkg::NUM_SLOTS; s++) begin
                xb.slot_req[s].wen <= 1'b0;
            end
        end
    end

    // select pipeline
    // request reg plus ram read reg is two cycles
    always_ff @(posedge clk) begin
        if (rst) begin
            lane_sel_d1 <= '0;
            lane_sel_d2 <= '0;
        end else begin
            lane_sel_d1 <= xb.lane_select;
            lane_sel_d2 <= lane_sel_d1;
        end
    end

    // one registered slot to lane mux per lane
    always_ff @(posedge clk) begin
        for (int l = 0; l < fhe_buf_pkg::NUM_LANES; l++) begin
            lane_data[l] <= xb.slot_rdata[lane_sel_d2[l]];
        end
    end

    // a routed write only comes from the write-back lane with its enable set
    for (genvar s = 0; s < fhe_buf_pkg::NUM_SLOTS; s++) begin : g_wen_chk
        a_wen_source: assert property (@(posedge clk) disable iff (rst)
            xb.slot_req[s].wen |-> $past((xb.slot_select[s] == '0) && xb.lane_req[0].wen));
    end

endmodule

`default_nettype wire

// File: hw/buffer_slot_bank.sv
`timescale 1ns/1ns
`default_nettype none

module buffer_slot_bank (
    input  wire logic clk,
    buf_xbar_if.bank  xb
);

    // one single port ram per slot
    logic [fhe_buf_pkg::WORD_W-1:0] mem [fhe_buf_pkg::NUM_SLOTS][fhe_buf_pkg::SLOT_DEPTH];

    always_ff @(posedge clk) begin
        for (int s = 0; s < fhe_buf_pkg::NUM_SLOTS; s++) begin
            if (xb.slot_req[s].wen) begin
                mem[s][xb.slot_req[s].waddr] <= xb.slot_req[s].wdata;
            end
            // read every cycle, old data on a same-address write
            xb.slot_rdata[s] <= mem[s][xb.slot_req[s].raddr];
        end
    end

endmodule

`default_nettype wire

// File: hw/cmd_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module cmd_decoder (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          cmd_req,
    input  wire fhe_buf_pkg::cmd_t             cmd,
    output logic                               cmd_ack,
    buf_xbar_if.ctrl                           xb,
    input  wire logic [fhe_buf_pkg::WORD_W-1:0] alu_result,
    output fhe_buf_pkg::opcode_e               alu_op,
    output logic                               rsp_load,
    input  wire logic                          rsp_busy
);

    fhe_buf_pkg::dec_state_e                 state;
    fhe_buf_pkg::cmd_t                       cmd_q;
    logic [fhe_buf_pkg::WAIT_CNT_W-1:0]      cnt;
    logic                                    reading;
    logic [fhe_buf_pkg::NUM_SLOTS-1:0]       wr_route;

    // command fields are held for the whole command
    always_ff @(posedge clk) begin
        if (state == fhe_buf_pkg::ST_IDLE && cmd_req) begin
            cmd_q <= cmd;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= fhe_buf_pkg::ST_IDLE;
            cnt <= '0;
            cmd_ack <= 1'b0;
        end else begin
            case (state)
                fhe_buf_pkg::ST_IDLE: begin
                    cnt <= '0;
                    // an immediate write needs no operand read
                    if (cmd_req && cmd.op == fhe_buf_pkg::OP_WRITE) begin
                        state <= fhe_buf_pkg::ST_WRITE;
                    end else if (cmd_req) begin
                        state <= fhe_buf_pkg::ST_READ;
                    end
                end
                fhe_buf_pkg::ST_READ: begin
                    state <= fhe_buf_pkg::ST_WAIT;
                end
                fhe_buf_pkg::ST_WAIT: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == fhe_buf_pkg::WAIT_CNT_W'(fhe_buf_pkg::WAIT_CYCLES - 1)) begin
                        cnt <= '0;
                        if (cmd_q.op == fhe_buf_pkg::OP_READ) begin
                            state <= fhe_buf_pkg::ST_RESULT;
                        end else begin
                            state <= fhe_buf_pkg::ST_WRITE;
                        end
                    end
                end
                fhe_buf_pkg::ST_WRITE: begin
                    // second cycle covers the xbar register, ram writes on its edge
                    if (cnt == '0) begin
                        cnt <= 1'b1;
                    end else begin
                        cmd_ack <= 1'b1;
                        state <= fhe_buf_pkg::ST_DONE;
                    end
                end
                fhe_buf_pkg::ST_RESULT: begin
                    // load once, then wait for the response handshake to finish
                    if (cnt == '0 && !rsp_busy) begin
                        cnt <= 1'b1;
                    end else if (cnt != '0 && !rsp_busy) begin
                        cmd_ack <= 1'b1;
                        state <= fhe_buf_pkg::ST_DONE;
                    end
                end
                fhe_buf_pkg::ST_DONE: begin
                    if (!cmd_req) begin
                        cmd_ack <= 1'b0;
                        state <= fhe_buf_pkg::ST_IDLE;
                    end
                end
                default: begin
                    state <= fhe_buf_pkg::ST_IDLE;
                end
            endcase
        end
    end

    assign rsp_load = (state == fhe_buf_pkg::ST_RESULT) && (cnt == '0) && !rsp_busy;

    assign reading = (state == fhe_buf_pkg::ST_READ) || (state == fhe_buf_pkg::ST_WAIT) ||
                     (state == fhe_buf_pkg::ST_RESULT);

    // alu sees the real opcode only while the operands of this command are in its stage
    always_comb begin
        if (state == fhe_buf_pkg::ST_WAIT &&
            cnt >= fhe_buf_pkg::WAIT_CNT_W'(fhe_buf_pkg::WAIT_CYCLES - 2)) begin
            alu_op = cmd_q.op;
        end else begin
            alu_op = fhe_buf_pkg::OP_COPY;
        end
    end

    always_comb begin
        // lane 0 reads operand a and carries the write-back
        xb.lane_req[0].raddr = cmd_q.src_a_addr;
        xb.lane_req[0].waddr = cmd_q.dst_addr;
        xb.lane_req[0].wdata = (cmd_q.op == fhe_buf_pkg::OP_WRITE) ? cmd_q.imm : alu_result;
        xb.lane_req[0].wen = (state == fhe_buf_pkg::ST_WRITE) && (cnt == '0);
        // lane 1 only ever reads operand b
        xb.lane_req[1].raddr = cmd_q.src_b_addr;
        xb.lane_req[1].waddr = '0;
        xb.lane_req[1].wdata = '0;
        xb.lane_req[1].wen = 1'b0;
        xb.lane_select[0] = cmd_q.src_a_slot;
        xb.lane_select[1] = cmd_q.src_b_slot;
        // idle slots listen to the read-only lane
        // operand a wins when a and b share one slot
        for (int s = 0; s < fhe_buf_pkg::NUM_SLOTS; s++) begin
            xb.slot_select[s] = fhe_buf_pkg::LANE_SEL_W'(1);
            if (reading && fhe_buf_pkg::SLOT_SEL_W'(s) == cmd_q.src_a_slot) begin
                xb.slot_select[s] = '0;
            end
            if (state == fhe_buf_pkg::ST_WRITE &&
                fhe_buf_pkg::SLOT_SEL_W'(s) == cmd_q.dst_slot) begin
                xb.slot_select[s] = '0;
            end
        end
    end

    // slots that would see a write enable after routing
    always_comb begin
        for (int s = 0; s < fhe_buf_pkg::NUM_SLOTS; s++) begin
            wr_route[s] = xb.lane_req[xb.slot_select[s]].wen;
        end
    end

    // ack only answers a request that is still raised
    a_ack_with_req: assert property (@(posedge clk) disable iff (rst)
        $rose(cmd_ack) |-> cmd_req);

    // a write is routed to at most one slot
    a_single_write: assert property (@(posedge clk) disable iff (rst)
        $onehot0(wr_route));

endmodule

`default_nettype wire

// File: hw/fhe_buf_pkg.sv
`default_nettype none

package fhe_buf_pkg;

    // datapath word and modulus, every stored value stays below MOD_Q
    localparam int WORD_W = 16;
    localparam logic [WORD_W-1:0] MOD_Q = 16'd12289;

    // buffer geometry
    localparam int NUM_SLOTS = 4;
    localparam int SLOT_DEPTH = 16;
    // lane 0 carries operand a and the write-back, lane 1 carries operand b
    localparam int NUM_LANES = 2;

    localparam int SLOT_SEL_W = $clog2(NUM_SLOTS);
    localparam int ADDR_W = $clog2(SLOT_DEPTH);
    localparam int LANE_SEL_W = $clog2(NUM_LANES);

    // request to alu result: xbar reg, ram read, xbar reg, alu reg
    localparam int WAIT_CYCLES = 4;
    localparam int WAIT_CNT_W = $clog2(WAIT_CYCLES);

    typedef enum logic [1:0] {
        OP_WRITE  = 2'd0,
        OP_COPY   = 2'd1,
        OP_ADDMOD = 2'd2,
        OP_READ   = 2'd3
    } opcode_e;

    typedef struct packed {
        opcode_e                 op;
        logic [SLOT_SEL_W-1:0]   dst_slot;
        logic [ADDR_W-1:0]       dst_addr;
        logic [SLOT_SEL_W-1:0]   src_a_slot;
        logic [ADDR_W-1:0]       src_a_addr;
        logic [SLOT_SEL_W-1:0]   src_b_slot;
        logic [ADDR_W-1:0]       src_b_addr;
        logic [WORD_W-1:0]       imm;
    } cmd_t;

    // one ram port request, as seen by a lane and by a slot
    typedef struct packed {
        logic [ADDR_W-1:0]   raddr;
        logic [ADDR_W-1:0]   waddr;
        logic [WORD_W-1:0]   wdata;
        logic                wen;
    } slot_req_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_READ,
        ST_WAIT,
        ST_WRITE,
        ST_RESULT,
        ST_DONE
    } dec_state_e;

endpackage

`default_nettype wire

// File: hw/fhe_buffer_top.sv
`timescale 1ns/1ns
`default_nettype none

module fhe_buffer_top (
    input  wire logic                               clk,
    input  wire logic                               rst,
    // command handshake
    input  wire logic                               cmd_req,
    output logic                                    cmd_ack,
    input  wire logic [1:0]                         op,
    input  wire logic [fhe_buf_pkg::SLOT_SEL_W-1:0] dst_slot,
    input  wire logic [fhe_buf_pkg::ADDR_W-1:0]     dst_addr,
    input  wire logic [fhe_buf_pkg::SLOT_SEL_W-1:0] src_a_slot,
    input  wire logic [fhe_buf_pkg::ADDR_W-1:0]     src_a_addr,
    input  wire logic [fhe_buf_pkg::SLOT_SEL_W-1:0] src_b_slot,
    input  wire logic [fhe_buf_pkg::ADDR_W-1:0]     src_b_addr,
    input  wire logic [fhe_buf_pkg::WORD_W-1:0]     imm,
    // response handshake
    output logic                                    rsp_req,
    input  wire logic                               rsp_ack,
    output logic [fhe_buf_pkg::WORD_W-1:0]          rsp_data
);

    fhe_buf_pkg::cmd_t                                          cmd;
    logic [fhe_buf_pkg::NUM_LANES-1:0][fhe_buf_pkg::WORD_W-1:0] lane_data;
    logic [fhe_buf_pkg::WORD_W-1:0]                             alu_result;
    fhe_buf_pkg::opcode_e                                       alu_op;
    logic                                                       rsp_load;
    logic                                                       rsp_busy;

    buf_xbar_if xb ();

    // pack the host fields into one command word
    always_comb begin
        cmd.op = fhe_buf_pkg::opcode_e'(op);
        cmd.dst_slot = dst_slot;
        cmd.dst_addr = dst_addr;
        cmd.src_a_slot = src_a_slot;
        cmd.src_a_addr = src_a_addr;
        cmd.src_b_slot = src_b_slot;
        cmd.src_b_addr = src_b_addr;
        cmd.imm = imm;
    end

    cmd_decoder i_cmd_decoder (
        .clk        (clk),
        .rst        (rst),
        .cmd_req    (cmd_req),
        .cmd        (cmd),
        .cmd_ack    (cmd_ack),
        .xb         (xb.ctrl),
        .alu_result (alu_result),
        .alu_op     (alu_op),
        .rsp_load   (rsp_load),
        .rsp_busy   (rsp_busy)
    );

    buffer_interconnect i_buffer_interconnect (
        .clk       (clk),
        .rst       (rst),
        .xb        (xb.xbar),
        .lane_data (lane_data)
    );

    buffer_slot_bank i_buffer_slot_bank (
        .clk (clk),
        .xb  (xb.bank)
    );

    lane_alu i_lane_alu (
        .clk        (clk),
        .rst        (rst),
        .alu_op     (alu_op),
        .lane_data  (lane_data),
        .alu_result (alu_result)
    );

    result_port i_result_port (
        .clk        (clk),
        .rst        (rst),
        .rsp_load   (rsp_load),
        .alu_result (alu_result),
        .rsp_busy   (rsp_busy),
        .rsp_req    (rsp_req),
        .rsp_ack    (rsp_ack),
        .rsp_data   (rsp_data)
    );

endmodule

`default_nettype wire

// File: hw/lane_alu.sv
`timescale 1ns/1ns
`default_nettype none

module lane_alu (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire fhe_buf_pkg::opcode_e  alu_op,
    input  wire logic [fhe_buf_pkg::NUM_LANES-1:0][fhe_buf_pkg::WORD_W-1:0] lane_data,
    output logic [fhe_buf_pkg::WORD_W-1:0] alu_result
);

    // one extra bit for the carry of a + b and the borrow of the reduction
    logic [fhe_buf_pkg::WORD_W:0] sum;
    logic [fhe_buf_pkg::WORD_W:0] diff;

    assign sum = {1'b0, lane_data[0]} + {1'b0, lane_data[1]};
    assign diff = sum - {1'b0, fhe_buf_pkg::MOD_Q};

    always_ff @(posedge clk) begin
        case (alu_op)
            fhe_buf_pkg::OP_ADDMOD: begin
                // both inputs below q, so one subtraction is enough
                if (diff[fhe_buf_pkg::WORD_W]) begin
                    alu_result <= sum[fhe_buf_pkg::WORD_W-1:0];
                end else begin
                    alu_result <= diff[fhe_buf_pkg::WORD_W-1:0];
                end
            end
            // copy and read pass operand a
            default: begin
                alu_result <= lane_data[0];
            end
        endcase
    end

    // bank contents must already be reduced
    a_operands_reduced: assert property (@(posedge clk) disable iff (rst)
        alu_op == fhe_buf_pkg::OP_ADDMOD |->
            (lane_data[0] < fhe_buf_pkg::MOD_Q) && (lane_data[1] < fhe_buf_pkg::MOD_Q));

endmodule

`default_nettype wire

// File: hw/result_port.sv
`timescale 1ns/1ns
`default_nettype none

module result_port (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire logic                           rsp_load,
    input  wire logic [fhe_buf_pkg::WORD_W-1:0] alu_result,
    output logic                                rsp_busy,
    output logic                                rsp_req,
    input  wire logic                           rsp_ack,
    output logic [fhe_buf_pkg::WORD_W-1:0]      rsp_data
);

    // set between ack rising and ack falling
    logic wait_drop;

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_req <= 1'b0;
            wait_drop <= 1'b0;
        end else if (rsp_load) begin
            rsp_req <= 1'b1;
        end else if (rsp_req && rsp_ack) begin
            rsp_req <= 1'b0;
            wait_drop <= 1'b1;
        end else if (wait_drop && !rsp_ack) begin
            wait_drop <= 1'b0;
        end
    end

    // data only changes on a load, which the decoder issues while idle
    always_ff @(posedge clk) begin
        if (rsp_load) begin
            rsp_data <= alu_result;
        end
    end

    assign rsp_busy = rsp_req || wait_drop;

    // host may sample rsp_data any time while req is up
    a_data_stable: assert property (@(posedge clk) disable iff (rst)
        rsp_req |=> !rsp_req || $stable(rsp_data));

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# builds the testbench with verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module tb_fhe_buffer \
    > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/Vtb_fhe_buffer > sim.log 2>&1

grep -q "SIMULATION FAILED" sim.log && { echo "test failed, see sim.log"; exit 1; }
grep -q "SIMULATION PASSED" sim.log || { echo "run did not finish, see sim.log"; exit 1; }
echo "test passed"

// File: verification/fhe_buffer_cases.txt
# columns: op dst_slot dst_addr src_a_slot src_a_addr src_b_slot src_b_addr imm expect
# op 0 write, 1 copy, 2 add mod 12289, 3 read of src a; expect is checked on reads only
# immediate writes, every slot, two words in slot 1
0 0 3  0 0  0 0  100   0
0 1 5  0 0  0 0  12000 0
0 2 0  0 0  0 0  1000  0
0 3 15 0 0  0 0  4321  0
0 1 9  0 0  0 0  777   0
3 0 0  0 3  0 0  0     100
3 0 0  1 5  0 0  0     12000
3 0 0  1 9  0 0  0     777
3 0 0  2 0  0 0  0     1000
3 0 0  3 15 0 0  0     4321
# copy slot 1 to slot 3, then destination and source
1 3 2  1 5  0 0  0     0
3 0 0  3 2  0 0  0     12000
3 0 0  1 5  0 0  0     12000
# 12000 + 1000 wraps to 711
2 0 7  1 5  2 0  0     0
3 0 0  0 7  0 0  0     711
# 100 + 4321 stays below q
2 2 4  0 3  3 15 0     0
3 0 0  2 4  0 0  0     4421
# result written back over operand a
2 1 9  1 9  0 7  0     0
3 0 0  1 9  0 0  0     1488
# largest reduced value plus 4321 wraps to 4320
0 2 0  0 0  0 0  12288 0
2 3 1  2 0  3 15 0     0
3 0 0  3 1  0 0  0     4320
3 0 0  0 3  0 0  0     100

// File: verification/tb_fhe_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module tb_fhe_buffer;

    // cycles any single wait may take before it is called a hang
    localparam int TIMEOUT_CYCLES = 200;

    logic                                   clk;
    logic                                   rst;
    logic                                   cmd_req;
    logic                                   cmd_ack;
    logic [1:0]                             op;
    logic [fhe_buf_pkg::SLOT_SEL_W-1:0]     dst_slot;
    logic [fhe_buf_pkg::ADDR_W-1:0]         dst_addr;
    logic [fhe_buf_pkg::SLOT_SEL_W-1:0]     src_a_slot;
    logic [fhe_buf_pkg::ADDR_W-1:0]         src_a_addr;
    logic [fhe_buf_pkg::SLOT_SEL_W-1:0]     src_b_slot;
    logic [fhe_buf_pkg::ADDR_W-1:0]         src_b_addr;
    logic [fhe_buf_pkg::WORD_W-1:0]         imm;
    logic                                   rsp_req;
    logic                                   rsp_ack;
    logic [fhe_buf_pkg::WORD_W-1:0]         rsp_data;

    int         mismatches;
    int         protocol_errors;
    int         timeouts;
    int         file_errors;
    int         cases_run;
    logic       timed_out;
    logic [7:0] lfsr;

    // handshake history, one entry per falling edge
    logic                                   ack_q;
    logic                                   req_q;
    logic                                   rsp_req_q;
    logic                                   rsp_ack_q;
    logic [fhe_buf_pkg::WORD_W-1:0]         rsp_data_q;
    // response handshake opened and not yet closed
    logic                                   rsp_open;
    logic                                   rsp_acked;

    fhe_buffer_top i_fhe_buffer_top (
        .clk        (clk),
        .rst        (rst),
        .cmd_req    (cmd_req),
        .cmd_ack    (cmd_ack),
        .op         (op),
        .dst_slot   (dst_slot),
        .dst_addr   (dst_addr),
        .src_a_slot (src_a_slot),
        .src_a_addr (src_a_addr),
        .src_b_slot (src_b_slot),
        .src_b_addr (src_b_addr),
        .imm        (imm),
        .rsp_req    (rsp_req),
        .rsp_ack    (rsp_ack),
        .rsp_data   (rsp_data)
    );

    // 20 ns period
    always #10 clk = ~clk;

    // 8 bit galois lfsr, taps for x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 8'hB8;
        end else begin
            return s >> 1;
        end
    endfunction

    // one lfsr step per bit taken
    task automatic rand_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr[0]);
            lfsr = lfsr_step(lfsr);
        end
    endtask

    // protocol monitor, samples mid cycle where everything is settled
    always @(negedge clk) begin
        if (!rst) begin
            if (cmd_ack && !ack_q && !cmd_req) begin
                $display("%0t ns: cmd_ack rose while cmd_req was low", $time);
                protocol_errors++;
            end
            if (!cmd_ack && ack_q && req_q) begin
                $display("%0t ns: cmd_ack fell before cmd_req was dropped", $time);
                protocol_errors++;
            end
            // a read is only acknowledged once the response is fully handed over
            if (cmd_ack && !ack_q && rsp_open) begin
                $display("%0t ns: cmd_ack rose before the response handshake ended", $time);
                protocol_errors++;
            end
            if (rsp_req && rsp_req_q && rsp_data !== rsp_data_q) begin
                $display("Mismatch at %0t ns: rsp_data got %0d expected %0d (held value)",
                         $time, rsp_data, rsp_data_q);
                mismatches++;
            end
            if (!rsp_req && rsp_req_q && !rsp_ack_q) begin
                $display("%0t ns: rsp_req dropped before rsp_ack was raised", $time);
                protocol_errors++;
            end
            if (rsp_req && !rsp_req_q) begin
                rsp_open = 1'b1;
            end
            if (rsp_open && rsp_ack) begin
                rsp_acked = 1'b1;
            end
            if (rsp_acked && !rsp_req && !rsp_ack) begin
                rsp_open = 1'b0;
                rsp_acked = 1'b0;
            end
        end
        ack_q = cmd_ack;
        req_q = cmd_req;
        rsp_req_q = rsp_req;
        rsp_ack_q = rsp_ack;
        rsp_data_q = rsp_data;
    end

    // host side of the command handshake
    task automatic send_cmd(input int c_op, c_dst_slot, c_dst_addr, c_a_slot, c_a_addr,
                            c_b_slot, c_b_addr, c_imm);
        int n;
        // fields settle one edge before req goes up
        @(posedge clk);
        op <= c_op[1:0];
        dst_slot <= c_dst_slot[fhe_buf_pkg::SLOT_SEL_W-1:0];
        dst_addr <= c_dst_addr[fhe_buf_pkg::ADDR_W-1:0];
        src_a_slot <= c_a_slot[fhe_buf_pkg::SLOT_SEL_W-1:0];
        src_a_addr <= c_a_addr[fhe_buf_pkg::ADDR_W-1:0];
        src_b_slot <= c_b_slot[fhe_buf_pkg::SLOT_SEL_W-1:0];
        src_b_addr <= c_b_addr[fhe_buf_pkg::ADDR_W-1:0];
        imm <= c_imm[fhe_buf_pkg::WORD_W-1:0];
        @(posedge clk);
        cmd_req <= 1'b1;
        n = 0;
        @(negedge clk);
        while (!cmd_ack && n < TIMEOUT_CYCLES) begin
            @(negedge clk);
            n++;
        end
        if (!cmd_ack) begin
            $display("%0t ns: timeout, cmd_ack never rose for opcode %0d", $time, c_op);
            timeouts++;
            timed_out = 1'b1;
            return;
        end
        @(posedge clk);
        cmd_req <= 1'b0;
        n = 0;
        @(negedge clk);
        while (cmd_ack && n < TIMEOUT_CYCLES) begin
            @(negedge clk);
            n++;
        end
        if (cmd_ack) begin
            $display("%0t ns: timeout, cmd_ack stayed high after cmd_req dropped", $time);
            timeouts++;
            timed_out = 1'b1;
        end
    endtask

    // host side of the response handshake, ack held off by a random delay
    task automatic serve_rsp(output logic [fhe_buf_pkg::WORD_W-1:0] data);
        int n;
        int delay;
        data = '0;
        n = 0;
        @(negedge clk);
        while (!rsp_req && n < TIMEOUT_CYCLES) begin
            @(negedge clk);
            n++;
        end
        if (!rsp_req) begin
            $display("%0t ns: timeout, rsp_req never rose for a read", $time);
            timeouts++;
            timed_out = 1'b1;
            return;
        end
        data = rsp_data;
        rand_bits(3, delay);
        repeat (delay) @(negedge clk);
        @(posedge clk);
        rsp_ack <= 1'b1;
        n = 0;
        @(negedge clk);
        while (rsp_req && n < TIMEOUT_CYCLES) begin
            @(negedge clk);
            n++;
        end
        if (rsp_req) begin
            $display("%0t ns: timeout, rsp_req stayed high after rsp_ack", $time);
            timeouts++;
            timed_out = 1'b1;
            return;
        end
        @(posedge clk);
        rsp_ack <= 1'b0;
    endtask

    // one line of the case file, reads run both handshakes side by side
    task automatic run_case(input int c_op, c_dst_slot, c_dst_addr, c_a_slot, c_a_addr,
                            c_b_slot, c_b_addr, c_imm, c_expect);
        logic [fhe_buf_pkg::WORD_W-1:0] got;
        got = '0;
        if (c_op == 3) begin
            fork
                send_cmd(c_op, c_dst_slot, c_dst_addr, c_a_slot, c_a_addr,
                         c_b_slot, c_b_addr, c_imm);
                serve_rsp(got);
            join
            if (!timed_out && got !== c_expect[fhe_buf_pkg::WORD_W-1:0]) begin
                $display("Mismatch at %0t ns: rsp_data got %0d expected %0d (slot %0d addr %0d)",
                         $time, got, c_expect, c_a_slot, c_a_addr);
                mismatches++;
            end
        end else begin
            send_cmd(c_op, c_dst_slot, c_dst_addr, c_a_slot, c_a_addr,
                     c_b_slot, c_b_addr, c_imm);
        end
        cases_run++;
    endtask

    initial begin
        int  fd;
        int  n;
        int  f[9];
        logic [8*160-1:0] line;
        clk = 1'b0;
        rst = 1'b1;
        cmd_req = 1'b0;
        op = '0;
        dst_slot = '0;
        dst_addr = '0;
        src_a_slot = '0;
        src_a_addr = '0;
        src_b_slot = '0;
        src_b_addr = '0;
        imm = '0;
        rsp_ack = 1'b0;
        rsp_open = 1'b0;
        rsp_acked = 1'b0;
        mismatches = 0;
        protocol_errors = 0;
        timeouts = 0;
        file_errors = 0;
        cases_run = 0;
        timed_out = 1'b0;
        lfsr = 8'd21;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        // both handshakes idle out of reset
        @(negedge clk);
        if (cmd_ack !== 1'b0) begin
            $display("Mismatch at %0t ns: cmd_ack got %b expected 0", $time, cmd_ack);
            mismatches++;
        end
        if (rsp_req !== 1'b0) begin
            $display("Mismatch at %0t ns: rsp_req got %b expected 0", $time, rsp_req);
            mismatches++;
        end
        fd = $fopen("verification/fhe_buffer_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open verification/fhe_buffer_cases.txt");
            file_errors++;
        end else begin
            while (!$feof(fd) && !timed_out) begin
                line = '0;
                // comment and blank lines give fewer than nine fields
                if ($fgets(line, fd) != 0) begin
                    n = $sscanf(line, "%d %d %d %d %d %d %d %d %d",
                                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
                    if (n == 9) begin
                        run_case(f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
                    end
                end
            end
            $fclose(fd);
        end
        if (cases_run == 0) begin
            $display("no command was run from the case file");
            file_errors++;
        end
        repeat (4) @(posedge clk);
        $display("cases %0d, mismatches %0d, protocol errors %0d, timeouts %0d, file errors %0d",
                 cases_run, mismatches, protocol_errors, timeouts, file_errors);
        if (mismatches + protocol_errors + timeouts + file_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
